// File: verilog/dcache_pkg.sv
// Words are 32 bits and lines hold four words while the set count is left to each module's set_bits
`default_nettype none

package dcache_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int line_w         = word_w * words_per_line;
    localparam int offset_bits    = $clog2(words_per_line);  // Word select inside a line
    localparam int addr_w         = 30;                      // Processor word address
    localparam int line_addr_w    = addr_w - offset_bits;    // Tag plus set index

    // --------------------------------------------------
    // Data and address types
    // --------------------------------------------------
    typedef logic [word_w-1:0] word_t;

    // Word k sits in bits 32k+31 down to 32k
    typedef logic [line_w-1:0] line_t;

    // Offset in the low bits, then set index, tag on top
    typedef logic [addr_w-1:0] word_addr_t;

    typedef logic [line_addr_w-1:0] line_addr_t;

    // --------------------------------------------------
    // Miss sequencer states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        idle       = 2'd0,  // Waiting for a miss
        write_back = 2'd1,  // Dirty victim going out
        refill     = 2'd2   // Requested line coming in
    } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/tag_lookup.sv
// Hit and stall are combinational on the held request and the LRU bit only moves on a hit
`timescale 1ns/1ps
`default_nettype none

module tag_lookup
    import dcache_pkg::*;
#(
    parameter int set_bits = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              proc_read,
    input  logic                              proc_write,
    input  word_addr_t                        proc_addr,
    input  logic                              fill,
    input  logic                              fill_dirty,
    output logic                              hit,
    output logic                              hit_way,
    output logic                              stall,
    output logic                              victim_way,
    output logic                              victim_dirty,
    output logic [line_addr_w-set_bits-1:0]   victim_tag
);
    localparam int n_sets = 1 << set_bits;
    localparam int tag_w  = line_addr_w - set_bits;

    logic [set_bits-1:0] set_idx;
    logic [tag_w-1:0]    req_tag;
    logic                req;
    logic [1:0]          way_hit;

    // --------------------------------------------------
    // Per way and set state
    // --------------------------------------------------
    logic [tag_w-1:0]       tag_q [2][n_sets];
    logic [1:0][n_sets-1:0] valid_q;
    logic [1:0][n_sets-1:0] dirty_q;
    logic [n_sets-1:0]      lru_q;   // Way to evict next

    assign set_idx = proc_addr[offset_bits +: set_bits];
    assign req_tag = proc_addr[addr_w-1 -: tag_w];
    assign req     = proc_read | proc_write;

    // Compare both ways at once
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];       // Ways never hold the same tag
    assign stall   = req & ~hit;

    // Victim is whatever the LRU bit points at
    assign victim_way   = lru_q[set_idx];
    assign victim_dirty = dirty_q[victim_way][set_idx];
    assign victim_tag   = tag_q[victim_way][set_idx];

    // --------------------------------------------------
    // State updates
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill) begin
            // Fill only comes during a miss, so no hit to handle here
            valid_q[victim_way][set_idx] <= 1'b1;
            dirty_q[victim_way][set_idx] <= fill_dirty;
        end else if (req && hit) begin
            lru_q[set_idx] <= ~hit_way;             // Other way ages
            if (proc_write) begin
                dirty_q[hit_way][set_idx] <= 1'b1;
            end
        end
    end

    // New tag goes into the victim slot
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[victim_way][set_idx] <= req_tag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/line_store.sv
// Data arrays power up unknown and only lines marked valid by the lookup may be read
`timescale 1ns/1ps
`default_nettype none

module line_store
    import dcache_pkg::*;
#(
    parameter int set_bits = 2
) (
    input  logic       clk,
    input  logic       proc_write,
    input  word_addr_t proc_addr,
    input  word_t      proc_wdata,
    input  logic       hit,
    input  logic       hit_way,
    input  logic       victim_way,
    input  logic       fill,
    input  line_t      mem_rdata,
    output word_t      proc_rdata,
    output line_t      victim_line
);
    localparam int n_sets = 1 << set_bits;

    logic [set_bits-1:0]    set_idx;
    logic [offset_bits-1:0] word_sel;

    line_t data_q [2][n_sets];

    assign set_idx  = proc_addr[offset_bits +: set_bits];
    assign word_sel = proc_addr[offset_bits-1:0];

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    assign proc_rdata  = data_q[hit_way][set_idx][word_sel*word_w +: word_w];
    assign victim_line = data_q[victim_way][set_idx];  // Write-back source

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill) begin
            data_q[victim_way][set_idx] <= mem_rdata;
        end else if (proc_write && hit) begin
            // Only the addressed word changes
            data_q[hit_way][set_idx][word_sel*word_w +: word_w] <= proc_wdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_sequencer.sv
// Handles one miss at a time and expects the processor address to stay put until stall drops
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer
    import dcache_pkg::*;
#(
    parameter int set_bits = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            proc_write,
    input  word_addr_t                      proc_addr,
    input  logic                            stall,
    input  logic                            victim_dirty,
    input  logic [line_addr_w-set_bits-1:0] victim_tag,
    input  line_t                           victim_line,
    input  logic                            mem_ready,
    output logic                            mem_read,
    output logic                            mem_write,
    output line_addr_t                      mem_addr,
    output line_t                           mem_wdata,
    output logic                            fill,
    output logic                            fill_dirty
);
    seq_state_t state_q;
    seq_state_t state_d;
    logic       write_q;   // Miss came from a store

    line_addr_t proc_line;
    line_addr_t victim_addr;

    assign proc_line   = proc_addr[addr_w-1:offset_bits];
    assign victim_addr = {victim_tag, proc_addr[offset_bits +: set_bits]};

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (stall) begin
                    state_d = victim_dirty ? write_back : refill;
                end
            end
            write_back: begin
                if (mem_ready) begin
                    state_d = refill;
                end
            end
            refill: begin
                if (mem_ready) begin
                    state_d = idle;   // Access hits next cycle
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == idle && stall) begin
                write_q <= proc_write;
            end
        end
    end

    // --------------------------------------------------
    // Request address and write-back data
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (state_q == idle && stall) begin
            if (victim_dirty) begin
                mem_addr  <= victim_addr;
                mem_wdata <= victim_line;   // Snapshot before refill overwrites it
            end else begin
                mem_addr <= proc_line;
            end
        end else if (state_q == write_back && mem_ready) begin
            mem_addr <= proc_line;
        end
    end

    // Request levels follow the state directly
    assign mem_write  = (state_q == write_back);
    assign mem_read   = (state_q == refill);
    assign fill       = (state_q == refill) && mem_ready;
    assign fill_dirty = write_q;

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
// Two-way write-back data cache with one miss in flight and requests held by the processor until stall drops
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int set_bits = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    // Processor side
    input  logic       proc_read,
    input  logic       proc_write,
    input  word_addr_t proc_addr,
    input  word_t      proc_wdata,
    output word_t      proc_rdata,
    output logic       stall,
    // Memory side
    output logic       mem_read,
    output logic       mem_write,
    output line_addr_t mem_addr,
    output line_t      mem_wdata,
    input  line_t      mem_rdata,
    input  logic       mem_ready
);
    localparam int tag_w = line_addr_w - set_bits;

    logic             hit;
    logic             hit_way;
    logic             victim_way;
    logic             victim_dirty;
    logic [tag_w-1:0] victim_tag;
    line_t            victim_line;
    logic             fill;        // Refill line arrives this cycle
    logic             fill_dirty;

    // --------------------------------------------------
    // Lookup: tags and replacement state
    // --------------------------------------------------
    tag_lookup #(
        .set_bits     (set_bits)
    ) u_tag_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .stall        (stall),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // Data lines of both ways
    line_store #(
        .set_bits    (set_bits)
    ) u_line_store (
        .clk         (clk),
        .proc_write  (proc_write),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill        (fill),
        .mem_rdata   (mem_rdata),
        .proc_rdata  (proc_rdata),
        .victim_line (victim_line)
    );

    // --------------------------------------------------
    // Memory side miss handling
    // --------------------------------------------------
    mem_sequencer #(
        .set_bits     (set_bits)
    ) u_mem_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .stall        (stall),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .fill         (fill),
        .fill_dirty   (fill_dirty)
    );

endmodule

`default_nettype wire

// File: tests/dcache_assert.sv
// Memory request handshake rules, checked only while reset is released
`timescale 1ns/1ps
`default_nettype none

module dcache_assert
    import dcache_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       mem_read,
    input logic       mem_write,
    input logic       mem_ready,
    input logic       fill,
    input line_addr_t mem_addr
);
    // --------------------------------------------------
    // Request protocol
    // --------------------------------------------------
    // Write-back hands over to the refill with no overlap
    write_then_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_write && mem_ready |=> mem_read && !mem_write
    ) else $error("write-back not followed by a refill on its own");

    // Requests hold with a steady address until ready
    read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_read && !mem_ready |=> mem_read && $stable(mem_addr)
    ) else $error("mem_read dropped or mem_addr moved before mem_ready");

    write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_write && !mem_ready |=> mem_write && $stable(mem_addr)
    ) else $error("mem_write dropped or mem_addr moved before mem_ready");

    fill_drops_request: assert property (
        @(posedge clk) disable iff (!rst_n) fill |=> !mem_read && !mem_write
    ) else $error("memory request still high after fill");  // Back to idle after the refill

endmodule

bind mem_sequencer dcache_assert u_dcache_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_ready (mem_ready),
    .fill      (fill),
    .mem_addr  (mem_addr)
);

`default_nettype wire

// File: tests/tb_dcache.sv
// Memory model fills untouched lines from an address pattern and the random mix stays in 64 words
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();
    localparam int set_bits        = 2;
    localparam int n_sets          = 1 << set_bits;
    localparam int tag_w           = line_addr_w - set_bits;
    localparam int clk_period      = 8;
    localparam int n_directed      = 20;
    localparam int n_random        = 400;
    localparam int n_ops           = n_directed + n_random + 2 * n_sets;
    localparam int watchdog_cycles = n_ops * (2 * 7 + 4) + 10;

    // Three lines in set 0 and three in set 1
    localparam word_addr_t line_a = 30'h0000_0100;
    localparam word_addr_t line_b = 30'h0000_0200;
    localparam word_addr_t line_c = 30'h0000_0300;
    localparam word_addr_t line_d = 30'h0000_0404;
    localparam word_addr_t line_e = 30'h0000_0504;
    localparam word_addr_t line_f = 30'h0000_0604;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       proc_read;
    logic       proc_write;
    word_addr_t proc_addr;
    word_t      proc_wdata;
    word_t      proc_rdata;
    logic       stall;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata = '0;
    logic       mem_ready = 1'b0;

    // Memory model and reference state
    line_t            mem_lines [line_addr_t];
    word_t            shadow [word_addr_t];
    logic             mem_busy = 1'b0;
    int               mem_wait = 0;
    logic [31:0]      mem_rng  = 32'd45570;
    logic [tag_w-1:0] m_tag [2][n_sets];
    logic             m_valid [2][n_sets];
    logic             m_dirty [2][n_sets];
    logic             m_lru [n_sets];
    line_addr_t       wb_addr_q [$];
    line_t            wb_line_q [$];
    line_addr_t       rd_addr_q [$];

    always #(clk_period / 2) clk = ~clk;

    dcache_top #(
        .set_bits   (set_bits)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .stall      (stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    // --------------------------------------------------
    // Reference functions
    // --------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t init_word(input word_addr_t a);
        return {a, 2'b10} ^ 32'hA5C3_0F1E;  // Distinct for every word address
    endfunction

    function automatic line_t init_line(input line_addr_t la);
        line_t l;
        for (int k = 0; k < words_per_line; k++) begin
            l[k*word_w +: word_w] = init_word({la, offset_bits'(k)});
        end
        return l;
    endfunction

    function automatic line_t mem_line(input line_addr_t la);
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        return init_line(la);
    endfunction

    function automatic word_t exp_read(input word_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic line_t shadow_line(input line_addr_t la);
        line_t l;
        for (int k = 0; k < words_per_line; k++) begin
            l[k*word_w +: word_w] = exp_read({la, offset_bits'(k)});
        end
        return l;
    endfunction

    // --------------------------------------------------
    // Failure reporting and compares
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run("word mismatch");
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run("line mismatch");
        end
    endtask

    task automatic check_line_addr(input string name, input line_addr_t got,
                                   input line_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run("line address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run("control level mismatch");
        end
    endtask

    // --------------------------------------------------
    // Slow memory, one-cycle ready after 1 to 6 cycles
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait > 1) begin
                mem_wait <= mem_wait - 1;
            end else begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    mem_lines[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata <= mem_line(mem_addr);
                end
            end
        end else if (mem_read || mem_write) begin
            mem_rng = lcg_step(mem_rng);
            mem_busy <= 1'b1;
            mem_wait <= int'(mem_rng[31:16]) % 6 + 1;
        end
    end

    // Memory side compare against the predicted misses
    always @(posedge clk) begin : mem_monitor
        line_addr_t ea;
        line_t      el;
        if (rst_n && mem_ready && mem_write) begin
            if (wb_addr_q.size() == 0) begin
                abort_run("write-back of a line the model holds clean or absent");
            end
            ea = wb_addr_q.pop_front();
            el = wb_line_q.pop_front();
            check_line_addr("mem_addr", mem_addr, ea);
            check_line("mem_wdata", mem_wdata, el);
        end
        if (rst_n && mem_ready && mem_read) begin
            if (wb_addr_q.size() != 0 || rd_addr_q.size() == 0) begin
                abort_run("refill out of order or not expected");
            end
            ea = rd_addr_q.pop_front();
            check_line_addr("mem_addr", mem_addr, ea);
        end
    end

    // --------------------------------------------------
    // One processor access, held until stall drops
    // --------------------------------------------------
    task automatic access(input logic wr, input word_addr_t a, input word_t d);
        logic [set_bits-1:0] s;
        logic [tag_w-1:0]    t;
        logic                hit_pred;
        logic                way;
        word_t               expv;
        s        = a[offset_bits +: set_bits];
        t        = a[addr_w-1 -: tag_w];
        hit_pred = 1'b0;
        way      = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][s] && m_tag[w][s] == t) begin
                hit_pred = 1'b1;
                way      = w[0];
            end
        end
        if (!hit_pred) begin
            way = m_lru[s];  // LRU way is the victim
            if (m_dirty[way][s]) begin
                wb_addr_q.push_back({m_tag[way][s], s});
                wb_line_q.push_back(shadow_line({m_tag[way][s], s}));
            end
            rd_addr_q.push_back(a[addr_w-1:offset_bits]);
            m_tag[way][s]   = t;
            m_valid[way][s] = 1'b1;
            m_dirty[way][s] = wr;
        end
        expv = exp_read(a);
        @(negedge clk);
        proc_read  = !wr;
        proc_write = wr;
        proc_addr  = a;
        proc_wdata = d;
        @(posedge clk);
        check_bit("stall", stall, !hit_pred);
        while (stall) begin
            @(posedge clk);
        end
        if (wr) begin
            shadow[a] = d;
        end else begin
            check_word("proc_rdata", proc_rdata, expv);
        end
        if (hit_pred) begin
            check_bit("mem_read", mem_read, 1'b0);
            check_bit("mem_write", mem_write, 1'b0);
        end
        if (rd_addr_q.size() != 0) begin
            abort_run("stall dropped before the refill arrived");
        end
        m_lru[s] = !way;
        if (wr) begin
            m_dirty[way][s] = 1'b1;
        end
    endtask

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        abort_run("watchdog expired, an access never completed");
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] stim_rng;
        word_addr_t  a;
        logic        wr;
        line_t       ln;
        stim_rng   = 32'd45570;
        rst_n      = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        for (int s = 0; s < n_sets; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        @(posedge clk);
        check_bit("mem_read", mem_read, 1'b0);
        check_bit("mem_write", mem_write, 1'b0);
        check_bit("stall", stall, 1'b0);
        access(1'b0, 30'h0000_0005, '0);
        access(1'b0, 30'h1234_5678, '0);

        // Write one word, neighbours keep their values
        access(1'b1, 30'h0000_0041, 32'hCAFE_0041);
        for (int k = 0; k < words_per_line; k++) begin
            access(1'b0, 30'h0000_0040 + word_addr_t'(k), '0);
        end

        // Two lines in set 0, then only hits
        access(1'b0, line_a, '0);
        access(1'b0, line_b, '0);
        access(1'b1, line_a + 1, 32'h1111_A001);
        access(1'b0, line_b, '0);
        access(1'b0, line_a + 1, '0);
        access(1'b1, line_b + 2, 32'h2222_B002);
        access(1'b0, line_b + 2, '0);
        access(1'b0, line_a, '0);

        access(1'b0, line_c, '0);      // Dirty B goes out
        access(1'b0, line_b + 2, '0);
        access(1'b0, line_d, '0);
        access(1'b0, line_e, '0);
        access(1'b0, line_f, '0);      // Clean eviction

        for (int i = 0; i < n_random; i++) begin
            stim_rng = lcg_step(stim_rng);
            a        = word_addr_t'(stim_rng[21:16]);
            wr       = stim_rng[27];
            stim_rng = lcg_step(stim_rng);
            access(wr, a, stim_rng);
        end

        // Two fresh lines per set push every dirty line out
        for (int s = 0; s < n_sets; s++) begin
            for (int j = 0; j < 2; j++) begin
                a = '0;
                a[addr_w-1] = 1'b1;
                a[offset_bits + set_bits] = j[0];
                a[offset_bits +: set_bits] = s[set_bits-1:0];
                access(1'b0, a, '0);
            end
        end
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;

        foreach (shadow[wa]) begin
            ln = mem_line(wa[addr_w-1:offset_bits]);
            check_word($sformatf("memory word %h", wa),
                       ln[wa[offset_bits-1:0]*word_w +: word_w], shadow[wa]);
        end
        if (wb_addr_q.size() != 0) begin
            abort_run("predicted write-backs never reached memory");
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/dcache_pkg.sv
verilog/tag_lookup.sv
verilog/line_store.sv
verilog/mem_sequencer.sv
verilog/dcache_top.sv
tests/dcache_assert.sv
tests/tb_dcache.sv

// File: Makefile
TOP := tb_dcache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

run: build
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log
